//--- tb.f
source/fpdiv_r64_pkg.sv
source/fpdiv_r4_qds.sv
source/fpdiv_r4_srt_step.sv
source/fpdiv_r64_block.sv
source/fpdiv_r64_iter_ctrl.sv
source/fpdiv_otf_conv.sv
source/fpdiv_r64_core.sv
verification/tb_clk_gen.sv
verification/fpdiv_r64_assert.sv
verification/tb_fpdiv_r64.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpdiv_r64
SEED      ?= 90
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

run: build
	out=$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_fpdiv_r64.sv
`timescale 1ns/100ps
// Radix-64 divider testbench
module tb_fpdiv_r64;
	import fpdiv_r64_pkg::*;

	localparam int ITER_NUM = 3;
	localparam int QUOT_W = ITER_NUM * 6;
	localparam int NUM_DIV = 200;
	localparam int TIMEOUT = 50;

	logic              clk;
	logic              rst_n_i;
	logic              start_i;
	rem_t              rem_init_i;
	divisor_t          divisor_i;
	logic              busy_o;
	logic              done_o;
	logic [QUOT_W-1:0] quot_o;
	rem_t              rem_s_o;
	rem_t              rem_c_o;

	tb_clk_gen #(
		.PERIOD_NS (20.0)
	) u_clk (
		.clk_o (clk)
	);

	fpdiv_r64_core #(
		.ITER_NUM (ITER_NUM)
	) dut0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.start_i    (start_i),
		.rem_init_i (rem_init_i),
		.divisor_i  (divisor_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.quot_o     (quot_o),
		.rem_s_o    (rem_s_o),
		.rem_c_o    (rem_c_o)
	);

// ======================================================================
// Failure reporting and random helpers
// ======================================================================

	task automatic report_failure(input string msg);
		$display("[ERROR] %0t %s", $time, msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
		$display("TB FAILED");
		$fatal(1);
	endtask

	function automatic logic [127:0] rand_wide();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// Divisor in [DIV_NORM_LO, DIV_NORM_HI)
	function automatic divisor_t pick_divisor();
		logic [127:0] span;
		span = 128'(DIV_NORM_HI - DIV_NORM_LO);
		return DIV_NORM_LO + divisor_t'(rand_wide() % span);
	endfunction

	// Largest start remainder that still converges, 4/3 of the divisor
	function automatic rem_t rem_limit(input divisor_t d);
		return rem_t'((128'(d) * 128'd4) / 128'd3);
	endfunction

	// Bound assertions raise a flag, turn it into a failure here
	always @(negedge clk) begin
		if (dut0.u_chk.err_seen) begin
			report_failure("a bound assertion failed");
		end
	end

// ======================================================================
// One division, optionally poking start while busy
// ======================================================================

	task automatic run_division(input divisor_t d, input rem_t w0, input logic poke);
		int           cyc;
		logic [127:0] exp_full;
		rem_t         exp_rem;
		rem_t         act_rem;
		rem_t         neg_rem;
		logic [127:0] mag;
		cyc = 0;
		start_i    = 1'b1;
		rem_init_i = w0;
		divisor_i  = d;
		@(negedge clk);
		start_i = 1'b0;
		if (poke) begin
			// Competing operands, the core must ignore them
			start_i    = 1'b1;
			rem_init_i = rem_t'(rand_wide());
			divisor_i  = pick_divisor();
		end
		while (!done_o) begin
			if (cyc >= TIMEOUT) begin
				report_failure("done never arrived");
			end
			assert (busy_o == 1'b1)
				else report_mismatch("busy_o", 128'd1, 128'(busy_o));
			@(negedge clk);
			start_i = 1'b0;
			cyc++;
		end
		assert (cyc == ITER_NUM)
			else report_mismatch("latency", 128'(ITER_NUM), 128'(cyc));
		// Identity: w_final = 4^(3N) * w0 - Q * 2d, modulo 2^REM_W
		exp_full = (128'(w0) << (6 * ITER_NUM)) - 128'(quot_o) * (128'(d) << 1);
		exp_rem  = exp_full[REM_W-1:0];
		act_rem  = rem_s_o + rem_c_o;
		assert (act_rem == exp_rem)
			else report_mismatch("rem_s_o+rem_c_o", 128'(exp_rem), 128'(act_rem));
		// Convergence: |w_final| <= 4/3 of the divisor
		if (act_rem[REM_W-1]) begin
			neg_rem = -act_rem;
			mag = 128'(neg_rem);
		end else begin
			mag = 128'(act_rem);
		end
		assert (mag * 128'd3 <= 128'(d) * 128'd4)
			else report_mismatch("|final remainder|", 128'(rem_limit(d)), mag);
		@(negedge clk);
		assert (done_o == 1'b0)
			else report_mismatch("done_o", 128'd0, 128'(done_o));
	endtask

	initial begin
		divisor_t d;
		rem_t     w0;
		rst_n_i    = 1'b0;
		start_i    = 1'b0;
		rem_init_i = '0;
		divisor_i  = DIV_NORM_LO;
		void'($urandom(90));
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		assert ((busy_o == 1'b0) && (done_o == 1'b0) && (quot_o == '0))
			else report_mismatch("busy_o,done_o,quot_o", 128'd0,
				128'({busy_o, done_o, quot_o}));
		for (int n = 0; n < NUM_DIV; n++) begin
			d = pick_divisor();
			// Edge cases first, then random remainders
			if (n == 0) begin
				w0 = '0;
			end else if (n == 1) begin
				w0 = rem_limit(d);
			end else begin
				w0 = rem_t'(rand_wide() % (128'(rem_limit(d)) + 128'd1));
			end
			run_division(d, w0, (n % 4) == 2);
			// Idle gap lets the hold assertion see a few cycles
			repeat ($urandom % 4) @(negedge clk);
		end
		if (dut0.u_chk.err_seen) begin
			report_failure("a bound assertion failed at the end");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

//--- verification/fpdiv_r64_assert.sv
`timescale 1ns/100ps
// Divider protocol checker
module fpdiv_r64_assert #(
	parameter int ITER_NUM = 3
) (
	input logic                    clk,
	input logic                    rst_n_i,
	input logic                    start_i,
	input logic                    busy_o,
	input logic                    done_o,
	input logic [ITER_NUM*6-1:0]   quot_o,
	input fpdiv_r64_pkg::rem_t     rem_s_o,
	input fpdiv_r64_pkg::rem_t     rem_c_o,
	input fpdiv_r64_pkg::divisor_t divisor_i,
	input fpdiv_r64_pkg::divisor_t divisor
);
	import fpdiv_r64_pkg::*;

	logic                  start_acc;
	// Accepted start, delayed by 1 up to ITER_NUM+1 edges
	logic [ITER_NUM+1:1]   acc_dly;
	// Own copy of the divisor taken at start
	divisor_t              div_copy;
	// Raised by any failing assertion, polled by the testbench top
	logic                  err_seen;

	initial err_seen = 1'b0;

	assign start_acc = start_i & ~busy_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			acc_dly <= '0;
		end else begin
			acc_dly <= {acc_dly[ITER_NUM:1], start_acc};
		end
	end

	always_ff @(posedge clk) begin
		if (start_acc) begin
			div_copy <= divisor_i;
		end
	end

// ======================================================================
// Timing and hold properties
// ======================================================================

	// Done comes exactly ITER_NUM edges after the accepting edge, one cycle wide
	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o == acc_dly[ITER_NUM+1])
		else begin
			$error("done_o out of place");
			err_seen = 1'b1;
		end

	// Busy covers the whole iteration and nothing more
	a_busy_window: assert property (@(posedge clk) disable iff (!rst_n_i)
		busy_o == (|acc_dly[ITER_NUM:1]))
		else begin
			$error("busy_o window wrong");
			err_seen = 1'b1;
		end

	// A start during busy must not touch the latched divisor
	a_div_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		busy_o |-> (divisor == div_copy))
		else begin
			$error("divisor changed while busy");
			err_seen = 1'b1;
		end

	// Results stay put while idle
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(!busy_o && !$past(busy_o)) |-> ($stable(quot_o) && $stable(rem_s_o)
			&& $stable(rem_c_o)))
		else begin
			$error("outputs moved while idle");
			err_seen = 1'b1;
		end

endmodule

bind fpdiv_r64_core fpdiv_r64_assert #(
	.ITER_NUM (ITER_NUM)
) u_chk (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.start_i   (start_i),
	.busy_o    (busy_o),
	.done_o    (done_o),
	.quot_o    (quot_o),
	.rem_s_o   (rem_s_o),
	.rem_c_o   (rem_c_o),
	.divisor_i (divisor_i),
	.divisor   (divisor)
);

//--- verification/tb_clk_gen.sv
`timescale 1ns/100ps
// Testbench clock source
module tb_clk_gen #(
	parameter real PERIOD_NS = 20.0
) (
	output logic clk_o
);

	// Free-running clock, starts low
	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

//--- source/fpdiv_r64_core.sv
`timescale 1ns/100ps
// Radix-64 fraction divider core
module fpdiv_r64_core #(
	parameter int ITER_NUM = 3
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    start_i,
	input  fpdiv_r64_pkg::rem_t     rem_init_i,
	input  fpdiv_r64_pkg::divisor_t divisor_i,
	output logic                    busy_o,
	output logic                    done_o,
	output logic [ITER_NUM*6-1:0]   quot_o,
	output fpdiv_r64_pkg::rem_t     rem_s_o,
	output fpdiv_r64_pkg::rem_t     rem_c_o
);
	import fpdiv_r64_pkg::*;

	// Registered remainder and its next value
	rem_t            rem_s;
	rem_t            rem_c;
	rem_t            nxt_s;
	rem_t            nxt_c;
	divisor_t        divisor;
	quot_dig_t [2:0] quot_dig;
	logic            init_en;
	logic            iter_en;

	fpdiv_r64_iter_ctrl #(
		.ITER_NUM (ITER_NUM)
	) u_ctrl (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.start_i    (start_i),
		.rem_init_i (rem_init_i),
		.divisor_i  (divisor_i),
		.nxt_s_i    (nxt_s),
		.nxt_c_i    (nxt_c),
		.rem_s_o    (rem_s),
		.rem_c_o    (rem_c),
		.divisor_o  (divisor),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.init_en_o  (init_en),
		.iter_en_o  (iter_en)
	);

	// Six quotient bits per clock
	fpdiv_r64_block u_block (
		.f_r_s_i    (rem_s),
		.f_r_c_i    (rem_c),
		.divisor_i  (divisor),
		.quot_dig_o (quot_dig),
		.f_r_s_o    (nxt_s),
		.f_r_c_o    (nxt_c)
	);

	fpdiv_otf_conv #(
		.ITER_NUM (ITER_NUM)
	) u_otf (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.init_en_i  (init_en),
		.iter_en_i  (iter_en),
		.quot_dig_i (quot_dig),
		.quot_o     (quot_o)
	);

	assign rem_s_o = rem_s;
	assign rem_c_o = rem_c;

endmodule

//--- source/fpdiv_otf_conv.sv
`timescale 1ns/100ps
// On-the-fly quotient conversion
module fpdiv_otf_conv #(
	parameter int ITER_NUM = 3
) (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           init_en_i,
	input  logic                           iter_en_i,
	input  fpdiv_r64_pkg::quot_dig_t [2:0] quot_dig_i,
	output logic [ITER_NUM*6-1:0]          quot_o
);
	import fpdiv_r64_pkg::*;

	localparam int QUOT_W = ITER_NUM * 6;

	// Q and Q minus one, digit 0 is the most significant of the cycle
	logic [QUOT_W-1:0] q_q;
	logic [QUOT_W-1:0] qm_q;
	logic [QUOT_W-1:0] q_chain  [0:3];
	logic [QUOT_W-1:0] qm_chain [0:3];

	if (QUOT_W > QUOT_W_MAX) begin : g_width_chk
		$error("quotient width exceeds QUOT_W_MAX");
	end

	assign q_chain[0]  = q_q;
	assign qm_chain[0] = qm_q;

	for (genvar i = 0; i < 3; i++) begin : g_dig
		logic       pos;
		logic       neg;
		logic [1:0] q_app;
		logic [1:0] qm_app;

		assign pos = quot_dig_i[i][DIG_P2] | quot_dig_i[i][DIG_P1];
		assign neg = quot_dig_i[i][DIG_N2] | quot_dig_i[i][DIG_N1];
		// q mod 4, so -1 -> 3 and -2 -> 2
		assign q_app = {quot_dig_i[i][DIG_P2] | quot_dig_i[i][DIG_N1] | quot_dig_i[i][DIG_N2],
			quot_dig_i[i][DIG_P1] | quot_dig_i[i][DIG_N1]};
		// (q - 1) mod 4
		assign qm_app = {quot_dig_i[i][DIG_Z0] | quot_dig_i[i][DIG_N1],
			quot_dig_i[i][DIG_P2] | quot_dig_i[i][DIG_Z0] | quot_dig_i[i][DIG_N2]};
		// Negative digit borrows, so Q continues from QM
		assign q_chain[i+1] = neg ? {qm_chain[i][QUOT_W-3:0], q_app}
			: {q_chain[i][QUOT_W-3:0], q_app};
		assign qm_chain[i+1] = pos ? {q_chain[i][QUOT_W-3:0], qm_app}
			: {qm_chain[i][QUOT_W-3:0], qm_app};
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || init_en_i) begin
			q_q  <= '0;
			qm_q <= '1;
		end else if (iter_en_i) begin
			q_q  <= q_chain[3];
			qm_q <= qm_chain[3];
		end
	end

	assign quot_o = q_q;

endmodule

//--- source/fpdiv_r64_iter_ctrl.sv
`timescale 1ns/100ps
// Divider iteration controller
module fpdiv_r64_iter_ctrl #(
	parameter int ITER_NUM = 3
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    start_i,
	input  fpdiv_r64_pkg::rem_t     rem_init_i,
	input  fpdiv_r64_pkg::divisor_t divisor_i,
	input  fpdiv_r64_pkg::rem_t     nxt_s_i,
	input  fpdiv_r64_pkg::rem_t     nxt_c_i,
	output fpdiv_r64_pkg::rem_t     rem_s_o,
	output fpdiv_r64_pkg::rem_t     rem_c_o,
	output fpdiv_r64_pkg::divisor_t divisor_o,
	output logic                    busy_o,
	output logic                    done_o,
	output logic                    init_en_o,
	output logic                    iter_en_o
);
	import fpdiv_r64_pkg::*;

	localparam int CNT_W = (ITER_NUM > 1) ? $clog2(ITER_NUM) : 1;

	ctrl_state_t      state;
	// Remaining updates after the current one
	logic [CNT_W-1:0] cnt;
	logic             start_acc;
	logic             last_iter;
	rem_t             rem_s_q;
	rem_t             rem_c_q;
	divisor_t         div_q;

	// Start only counts while idle
	assign start_acc = start_i & (state == ST_IDLE);
	assign last_iter = (state == ST_ITER) & (cnt == '0);

// ======================================================================
// FSM and counter
// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state  <= ST_IDLE;
			cnt    <= '0;
			done_o <= 1'b0;
		end else begin
			// Pulse follows the final update edge
			done_o <= last_iter;
			case (state)
				ST_IDLE: begin
					if (start_acc) begin
						state <= ST_ITER;
						cnt   <= CNT_W'(ITER_NUM - 1);
					end
				end
				ST_ITER: begin
					if (last_iter) begin
						state <= ST_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Remainder and divisor hold
	// carry starts at zero, so the sum alone is the initial value
	always_ff @(posedge clk) begin
		if (start_acc) begin
			rem_s_q <= rem_init_i;
			rem_c_q <= '0;
			div_q   <= divisor_i;
		end else if (state == ST_ITER) begin
			rem_s_q <= nxt_s_i;
			rem_c_q <= nxt_c_i;
		end
	end

	assign rem_s_o   = rem_s_q;
	assign rem_c_o   = rem_c_q;
	assign divisor_o = div_q;
	assign busy_o    = (state == ST_ITER);
	assign init_en_o = start_acc;
	assign iter_en_o = (state == ST_ITER);

endmodule

//--- source/fpdiv_r64_block.sv
`timescale 1ns/100ps
// Three radix-4 steps per cycle
module fpdiv_r64_block (
	input  fpdiv_r64_pkg::rem_t            f_r_s_i,
	input  fpdiv_r64_pkg::rem_t            f_r_c_i,
	input  fpdiv_r64_pkg::divisor_t        divisor_i,
	output fpdiv_r64_pkg::quot_dig_t [2:0] quot_dig_o,
	output fpdiv_r64_pkg::rem_t            f_r_s_o,
	output fpdiv_r64_pkg::rem_t            f_r_c_o
);
	import fpdiv_r64_pkg::*;

	// Divisor aligned to the remainder and its multiples
	rem_t            divisor_ext;
	rem_t            div_pos1;
	rem_t            div_pos2;
	rem_t            div_neg1;
	rem_t            div_neg2;
	rem_spec_t [4:0] mul_top;

	// Remainders between steps
	rem_t            f_r_s_1st;
	rem_t            f_r_c_1st;
	rem_t            f_r_s_2nd;
	rem_t            f_r_c_2nd;

	// Estimates fed to digit selection
	rem_msb_t        rem_msb_1st;
	rem_msb_t        rem_msb_2nd;
	rem_msb_t        rem_msb_3rd;

	// Speculative estimates
	rem_spec_t [4:0] spec_2nd;
	rem_spec_t [4:0] cand_top_1st;
	rem_spec_t       top_1st_sel;
	rem_spec_t [4:0] spec_3rd;
	rem_spec_t       est_2nd_full;
	rem_spec_t       est_3rd_full;

	// One-hot select of a speculative estimate
	function automatic rem_spec_t sel_spec(input quot_dig_t dig, input rem_spec_t [4:0] v);
		rem_spec_t res;
		res = '0;
		for (int k = 0; k < 5; k++) begin
			res = res | ({SPEC_W{dig[k]}} & v[k]);
		end
		return res;
	endfunction

	assign divisor_ext = {2'b00, divisor_i, 1'b0};
	assign div_pos1 = divisor_ext;
	assign div_pos2 = {divisor_ext[REM_W-2:0], 1'b0};
	// One's complement, the +1 enters as carry-in inside the step
	assign div_neg1 = ~div_pos1;
	assign div_neg2 = ~div_pos2;

	// Multiple tops aligned with the 7-bit window of the next 4w
	assign mul_top[DIG_N2] = div_pos2[REM_W-3 -: SPEC_W];
	assign mul_top[DIG_N1] = div_pos1[REM_W-3 -: SPEC_W];
	assign mul_top[DIG_Z0] = '0;
	assign mul_top[DIG_P1] = div_neg1[REM_W-3 -: SPEC_W];
	assign mul_top[DIG_P2] = div_neg2[REM_W-3 -: SPEC_W];

// ======================================================================
// Step 1, estimate straight from the register tops
// ======================================================================

	assign rem_msb_1st = f_r_s_i[REM_W-3 -: MSB_W] + f_r_c_i[REM_W-3 -: MSB_W];

	fpdiv_r4_srt_step u_step_1st (
		.f_r_s_i    (f_r_s_i),
		.f_r_c_i    (f_r_c_i),
		.rem_msb_i  (rem_msb_1st),
		.div_pos1_i (div_pos1),
		.div_pos2_i (div_pos2),
		.div_neg1_i (div_neg1),
		.div_neg2_i (div_neg2),
		.quot_dig_o (quot_dig_o[0]),
		.f_r_s_o    (f_r_s_1st),
		.f_r_c_o    (f_r_c_1st),
		.spec_msb_o (cand_top_1st)
	);

// ======================================================================
// Step 2, estimate picked by digit 1 from five precomputed sums
// ======================================================================

	for (genvar k = 0; k < 5; k++) begin : g_spec
		assign spec_2nd[k] = f_r_s_i[REM_W-5 -: SPEC_W] + f_r_c_i[REM_W-5 -: SPEC_W]
			+ mul_top[k];
		// Step 3 adds the multiples onto the chosen step-1 candidate top
		assign spec_3rd[k] = top_1st_sel + mul_top[k];
	end

	assign est_2nd_full = sel_spec(quot_dig_o[0], spec_2nd);
	// Extra LSB only narrows the truncation error, drop it here
	assign rem_msb_2nd = est_2nd_full[SPEC_W-1:1];
	assign top_1st_sel = sel_spec(quot_dig_o[0], cand_top_1st);

	fpdiv_r4_srt_step u_step_2nd (
		.f_r_s_i    (f_r_s_1st),
		.f_r_c_i    (f_r_c_1st),
		.rem_msb_i  (rem_msb_2nd),
		.div_pos1_i (div_pos1),
		.div_pos2_i (div_pos2),
		.div_neg1_i (div_neg1),
		.div_neg2_i (div_neg2),
		.quot_dig_o (quot_dig_o[1]),
		.f_r_s_o    (f_r_s_2nd),
		.f_r_c_o    (f_r_c_2nd),
		.spec_msb_o ()
	);

// ======================================================================
// Step 3, estimate picked by digit 2
// ======================================================================

	assign est_3rd_full = sel_spec(quot_dig_o[1], spec_3rd);
	assign rem_msb_3rd = est_3rd_full[SPEC_W-1:1];

	fpdiv_r4_srt_step u_step_3rd (
		.f_r_s_i    (f_r_s_2nd),
		.f_r_c_i    (f_r_c_2nd),
		.rem_msb_i  (rem_msb_3rd),
		.div_pos1_i (div_pos1),
		.div_pos2_i (div_pos2),
		.div_neg1_i (div_neg1),
		.div_neg2_i (div_neg2),
		.quot_dig_o (quot_dig_o[2]),
		.f_r_s_o    (f_r_s_o),
		.f_r_c_o    (f_r_c_o),
		.spec_msb_o ()
	);

endmodule

//--- source/fpdiv_r4_srt_step.sv
`timescale 1ns/100ps
// Radix-4 SRT step, carry-save remainder
module fpdiv_r4_srt_step (
	input  fpdiv_r64_pkg::rem_t            f_r_s_i,
	input  fpdiv_r64_pkg::rem_t            f_r_c_i,
	input  fpdiv_r64_pkg::rem_msb_t        rem_msb_i,
	input  fpdiv_r64_pkg::rem_t            div_pos1_i,
	input  fpdiv_r64_pkg::rem_t            div_pos2_i,
	input  fpdiv_r64_pkg::rem_t            div_neg1_i,
	input  fpdiv_r64_pkg::rem_t            div_neg2_i,
	output fpdiv_r64_pkg::quot_dig_t       quot_dig_o,
	output fpdiv_r64_pkg::rem_t            f_r_s_o,
	output fpdiv_r64_pkg::rem_t            f_r_c_o,
	output fpdiv_r64_pkg::rem_spec_t [4:0] spec_msb_o
);
	import fpdiv_r64_pkg::*;

	// 4w in carry-save form
	rem_t       sh_s;
	rem_t       sh_c;
	// Addend and carry-in per digit, indexed like quot_dig_t
	rem_t [4:0] mult;
	logic [4:0] cin;
	// Speculative candidates for every digit
	rem_t [4:0] cand_s;
	rem_t [4:0] cand_c;
	rem_t [4:0] cand_maj;

	assign sh_s = {f_r_s_i[REM_W-3:0], 2'b00};
	assign sh_c = {f_r_c_i[REM_W-3:0], 2'b00};

	// Negative digits add +d or +2d, positive ones add the inverted
	// multiple plus one through the carry LSB
	assign mult[DIG_N2] = div_pos2_i;
	assign mult[DIG_N1] = div_pos1_i;
	assign mult[DIG_Z0] = '0;
	assign mult[DIG_P1] = div_neg1_i;
	assign mult[DIG_P2] = div_neg2_i;
	assign cin = 5'b00011;

// ======================================================================
// Candidate remainders, computed before the digit is known
// ======================================================================

	for (genvar k = 0; k < 5; k++) begin : g_cand
		// 3:2 compressor
		assign cand_s[k] = sh_s ^ sh_c ^ mult[k];
		assign cand_maj[k] = (sh_s & sh_c) | (sh_s & mult[k]) | (sh_c & mult[k]);
		assign cand_c[k] = {cand_maj[k][REM_W-2:0], cin[k]};
		// Top of the candidate, two steps ahead of its own use
		assign spec_msb_o[k] = cand_s[k][REM_W-5 -: SPEC_W] + cand_c[k][REM_W-5 -: SPEC_W];
	end

	fpdiv_r4_qds u_qds (
		.rem_i      (rem_msb_i),
		.quot_dig_o (quot_dig_o)
	);

	// One-hot AND-OR pick, no priority
	always_comb begin
		f_r_s_o = '0;
		f_r_c_o = '0;
		for (int k = 0; k < 5; k++) begin
			f_r_s_o = f_r_s_o | ({REM_W{quot_dig_o[k]}} & cand_s[k]);
			f_r_c_o = f_r_c_o | ({REM_W{quot_dig_o[k]}} & cand_c[k]);
		end
	end

endmodule

//--- source/fpdiv_r4_qds.sv
`timescale 1ns/100ps
// Radix-4 quotient digit selection
module fpdiv_r4_qds (
	input  fpdiv_r64_pkg::rem_msb_t  rem_i,
	output fpdiv_r64_pkg::quot_dig_t quot_dig_o
);
	import fpdiv_r64_pkg::*;

	// Two's complement estimate of 4w, LSB weight 1/8
	logic signed [MSB_W-1:0] est;

	assign est = rem_i;

	// Comparator ladder against constant thresholds
	// Exactly one branch fires, so the output stays one-hot
	always_comb begin
		quot_dig_o = '0;
		if (est >= QDS_TH_P2) begin
			quot_dig_o[DIG_P2] = 1'b1;
		end else if (est >= QDS_TH_P1) begin
			quot_dig_o[DIG_P1] = 1'b1;
		end else if (est >= QDS_TH_Z0) begin
			quot_dig_o[DIG_Z0] = 1'b1;
		end else if (est >= QDS_TH_N1) begin
			quot_dig_o[DIG_N1] = 1'b1;
		end else begin
			// Large negative remainder
			quot_dig_o[DIG_N2] = 1'b1;
		end
	end

endmodule

//--- source/fpdiv_r64_pkg.sv
// Radix-64 divider shared definitions
package fpdiv_r64_pkg;

// ======================================================================
// Widths
// ======================================================================

	// Double precision fraction including the hidden bit
	localparam int FRAC_W = 53;
	// Prescaled divisor carries three extra low bits
	localparam int DIV_W = FRAC_W + 4;
	// Three integer bits, fraction, guard bits and one spare LSB
	localparam int REM_W = 3 + FRAC_W + 3 + 1;
	// Digit selection looks at six top bits, speculation keeps one more
	localparam int MSB_W = 6;
	localparam int SPEC_W = 7;
	// Six quotient bits per cycle, up to twelve cycles
	localparam int QUOT_W_MAX = 72;

	typedef logic [REM_W-1:0] rem_t;
	typedef logic [DIV_W-1:0] divisor_t;
	typedef logic [MSB_W-1:0] rem_msb_t;
	typedef logic [SPEC_W-1:0] rem_spec_t;

	// One-hot digit, bit 4 down to bit 0 is n2, n1, z0, p1, p2
	typedef logic [4:0] quot_dig_t;
	localparam int DIG_N2 = 4;
	localparam int DIG_N1 = 3;
	localparam int DIG_Z0 = 2;
	localparam int DIG_P1 = 1;
	localparam int DIG_P2 = 0;

// ======================================================================
// Digit selection thresholds
// ======================================================================

	// Estimate is signed with 1/8 resolution, valid for the range below
	localparam int QDS_TH_P2 = 12;
	localparam int QDS_TH_P1 = 4;
	localparam int QDS_TH_Z0 = -4;
	localparam int QDS_TH_N1 = -13;

	// Normalized divisor range, [1, 9/8) after the one-bit extension
	// Upper bound is exclusive
	localparam divisor_t DIV_NORM_LO = divisor_t'(1) << (DIV_W - 1);
	localparam divisor_t DIV_NORM_HI = DIV_NORM_LO + (DIV_NORM_LO >> 3);
	// Convergence needs 0 <= rem_init <= 4/3 of divisor_i,
	// which is 2/3 of the extended divisor used by the recurrence

	typedef enum logic {
		ST_IDLE,
		ST_ITER
	} ctrl_state_t;

endpackage
